/* filelist.f */
verilog/acc_cpu_pkg.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_writeback.sv
verilog/wishbone_manager.sv
verilog/team_top.sv
test/team_top_tb.sv

/* test/team_top_tb.sv */
// Directed testbench for the accumulator processor top level.
// A 32-word Wishbone memory model with random ack delay sits on the bus.
// Each test task drives instructions through gpio_in and checks the pins.

module team_top_tb;
    import acc_cpu_pkg::*;

    localparam word_t base_adr = 32'h3000_0000;
    localparam int timeout_cycles = 50;

    logic        clk;
    logic        reset;
    logic        en;
    logic [33:0] gpio_in;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;
    word_t       wb_adr;
    word_t       wb_dat_w;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    word_t       wb_dat_r;
    logic        wb_ack;

    word_t mem [0:31];
    integer seed;
    int     ack_delay;
    int     errors;
    int     err_start;
    int     checks;
    int     tests;
    int     failed_tests;
    string  test_name;
    acc_t   model_acc;

    team_top #(
        .wb_base (base_adr)
    ) team_top_inst (
        .clk      (clk),
        .reset    (reset),
        .en       (en),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oeb (gpio_oeb),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #50 clk = ~clk;

    // initial memory contents depend on the full byte address
    function automatic word_t fill_word(input int idx);
        return (base_adr + idx * 4) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic int word_index(input word_t adr);
        return ((adr - base_adr) >> 2) & 31;
    endfunction

    // reference accumulator update
    function automatic acc_t model_op(input acc_t a, input opcode_t op, input imm_t imm);
        case (op)
            op_ldi:  return {3'b000, imm};
            op_addi: return a + {3'b000, imm};
            op_subi: return a - {3'b000, imm};
            op_xori: return a ^ {3'b000, imm};
            default: return a;
        endcase
    endfunction

    // memory model that acks after 0 to 3 idle cycles on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            wb_ack = 1'b0;
        end else if (wb_ack) begin
            // ack seen at the last rising edge, next cycle gets a new delay
            wb_ack = 1'b0;
            ack_delay = $unsigned($random(seed)) % 4;
        end else if (wb_cyc && wb_stb) begin
            if (ack_delay > 0) begin
                ack_delay--;
            end else begin
                assert (wb_sel == 4'hf && wb_adr[1:0] == 2'b00 &&
                        (wb_adr - base_adr) < 32'd128) else begin
                    $display("bad bus cycle in %s, address %h byte select %h",
                             test_name, wb_adr, wb_sel);
                    errors++;
                end
                if (wb_we) begin
                    mem[word_index(wb_adr)] = wb_dat_w;
                end else begin
                    wb_dat_r = mem[word_index(wb_adr)];
                end
                wb_ack = 1'b1;
            end
        end
    end

    task automatic check_value(input string what, input logic [33:0] expected,
                               input logic [33:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("mismatch in %s, %s: expected %0h actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        if (errors > err_start) begin
            failed_tests++;
            $display("test %s failed", test_name);
        end else begin
            $display("test %s passed", test_name);
        end
    endtask

    // one-cycle strobe that returns on the next falling edge
    task automatic send_instr(input opcode_t op, input imm_t imm);
        gpio_in[instr_lsb +: 8] = {op, imm};
        gpio_in[strobe_bit] = 1'b1;
        @(negedge clk);
        gpio_in[strobe_bit] = 1'b0;
    endtask

    task automatic alu_step(input opcode_t op, input imm_t imm);
        send_instr(op, imm);
        model_acc = model_op(model_acc, op, imm);
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (gpio_out[busy_bit] !== level && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (gpio_out[busy_bit] !== level) begin
            $display("timeout in %s, busy never went to %0d", test_name, level);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    // ld or st followed by a wait for the whole bus cycle
    task automatic mem_access(input opcode_t op, input imm_t imm);
        send_instr(op, imm);
        wait_busy(1'b1);
        wait_busy(1'b0);
    endtask

    // out plus one more edge for out_byte to settle
    task automatic check_out(input string what, input acc_t expected);
        send_instr(op_out, 5'd0);
        @(negedge clk);
        check_value(what, expected, gpio_out[out_lsb +: 8]);
    endtask

    task automatic reset_state_test();
        start_test("reset_state");
        check_value("output byte", 0, gpio_out[out_lsb +: 8]);
        check_value("busy", 0, gpio_out[busy_bit]);
        check_value("zero flag", 1, gpio_out[zero_bit]);
        check_value("wb_cyc", 0, wb_cyc);
        check_value("gpio_oeb", ~(34'h3ff << 8), gpio_oeb);
        finish_test();
    endtask

    task automatic alu_chain_test();
        start_test("alu_chain");
        // wraps below zero, then past 255
        alu_step(op_ldi, 5'd3);
        alu_step(op_subi, 5'd5);
        alu_step(op_addi, 5'd31);
        alu_step(op_xori, 5'd21);
        alu_step(op_subi, 5'd9);
        check_out("chain result", model_acc);
        check_value("zero flag after chain", model_acc == 0, gpio_out[zero_bit]);
        alu_step(op_ldi, 5'd7);
        alu_step(op_subi, 5'd7);
        @(negedge clk);
        check_value("zero flag after subi", 1, gpio_out[zero_bit]);
        check_out("zero result", model_acc);
        finish_test();
    endtask

    task automatic store_load_test();
        start_test("store_load");
        alu_step(op_ldi, 5'd22);
        alu_step(op_addi, 5'd31);
        mem_access(op_st, 5'd5);
        check_value("stored word", {24'd0, model_acc}, mem[5]);
        alu_step(op_ldi, 5'd1);
        mem_access(op_ld, 5'd5);
        model_acc = mem[5][7:0];
        check_out("loaded byte", 8'd53);
        // untouched word still holds its fill
        mem_access(op_ld, 5'd9);
        model_acc = acc_t'(fill_word(9));
        check_out("fill byte", model_acc);
        finish_test();
    endtask

    task automatic dropped_strobe_test();
        start_test("dropped_strobes");
        alu_step(op_ldi, 5'd23);
        send_instr(op_st, 5'd3);
        // lands in the cycle right after the store
        send_instr(op_ldi, 5'd9);
        check_value("busy during store", 1, gpio_out[busy_bit]);
        send_instr(op_ldi, 5'd30);
        wait_busy(1'b0);
        check_out("output after drops", model_acc);
        check_value("stored word", {24'd0, model_acc}, mem[3]);
        finish_test();
    endtask

    task automatic disabled_test();
        start_test("disabled");
        en = 1'b0;
        @(negedge clk);
        check_value("gpio_out while disabled", 0, gpio_out);
        check_value("gpio_oeb while disabled", '1, gpio_oeb);
        send_instr(op_ldi, 5'd4);
        send_instr(op_out, 5'd0);
        @(negedge clk);
        check_value("gpio_out after strobes", 0, gpio_out);
        en = 1'b1;
        @(negedge clk);
        check_out("accumulator after enable", model_acc);
        check_value("zero flag after enable", model_acc == 0, gpio_out[zero_bit]);
        finish_test();
    endtask

    initial begin
        seed = 59;
        ack_delay = $unsigned($random(seed)) % 4;
        clk = 1'b0;
        reset = 1'b1;
        en = 1'b1;
        gpio_in = '0;
        wb_ack = 1'b0;
        wb_dat_r = '0;
        errors = 0;
        err_start = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        test_name = "none";
        model_acc = '0;
        for (int i = 0; i < 32; i++) begin
            mem[i] = fill_word(i);
        end

        // four rising edges under reset
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        reset_state_test();
        alu_chain_test();
        store_load_test();
        dropped_strobe_test();
        disabled_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/acc_cpu_pkg.sv */
// Shared types and pin positions for the accumulator processor.
// Every RTL file imports this package. Load it first in the file list.

package acc_cpu_pkg;

    // 3-bit opcode in bits 7 to 5 of the instruction byte
    // encoding follows declaration order, so op_ldi is 0 and op_nop is 7
    typedef enum logic [2:0] {
        op_ldi,
        op_addi,
        op_subi,
        op_xori,
        op_ld,
        op_st,
        op_out,
        op_nop
    } opcode_t;

    // immediate field, doubles as a word index for loads and stores
    typedef logic [4:0] imm_t;

    // accumulator and everything that lands in it
    typedef logic [7:0] acc_t;

    // wishbone address and data words
    typedef logic [31:0] word_t;

    // gpio_in positions
    // instruction byte occupies instr_lsb up to instr_lsb + 7
    localparam int unsigned instr_lsb = 0;
    // single-cycle instruction strobe
    localparam int unsigned strobe_bit = 8;

    // gpio_out positions
    // output byte from op_out
    localparam int unsigned out_lsb = 8;
    // high while a bus cycle is running
    localparam int unsigned busy_bit = 16;
    // set when the accumulator is zero
    localparam int unsigned zero_bit = 17;

    // number of driven status pins, out_lsb through zero_bit
    localparam int unsigned status_pins = zero_bit - out_lsb + 1;

endpackage

/* verilog/alu_execute.sv */
// Execute stage. Pure combinational arithmetic and logic on the
// accumulator and the decoded immediate. The result is only written
// back for the ALU opcodes.

module alu_execute (
    input  acc_cpu_pkg::acc_t    acc,
    input  acc_cpu_pkg::opcode_t dec_op,
    input  acc_cpu_pkg::imm_t    dec_imm,
    output acc_cpu_pkg::acc_t    alu_result
);
    import acc_cpu_pkg::*;

    acc_t imm_ext;

    // immediate widened with zeros
    assign imm_ext = {3'b000, dec_imm};

    always_comb begin
        unique case (dec_op)
            // load immediate
            op_ldi: begin
                alu_result = imm_ext;
            end
            // add wraps modulo 256
            op_addi: begin
                alu_result = acc + imm_ext;
            end
            // subtract wraps below zero
            op_subi: begin
                alu_result = acc - imm_ext;
            end
            op_xori: begin
                alu_result = acc ^ imm_ext;
            end
            // memory, output and nop leave acc alone
            default: begin
                alu_result = acc;
            end
        endcase
    end

endmodule

/* verilog/instr_decode.sv */
// Decode stage. Samples the instruction strobe from the pins and
// registers opcode and immediate for one cycle. A strobe that arrives
// while disabled or busy is dropped and leaves no trace.

module instr_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    input  logic [7:0]           instr_byte,
    input  logic                 strobe,
    input  logic                 busy,
    output logic                 dec_valid,
    output acc_cpu_pkg::opcode_t dec_op,
    output acc_cpu_pkg::imm_t    dec_imm
);
    import acc_cpu_pkg::*;

    opcode_t field_op;
    imm_t    field_imm;
    logic    mem_pending;
    logic    accept;

    // split the byte into its two fields
    assign field_op  = opcode_t'(instr_byte[7:5]);
    assign field_imm = instr_byte[4:0];

    // a memory op sitting in this stage has not raised busy yet,
    // so the next strobe has to be held off here
    assign mem_pending = dec_valid && (dec_op == op_ld || dec_op == op_st);

    // acceptance rule
    assign accept = strobe && en && !busy && !mem_pending;

    // valid pulse and opcode
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_op    <= op_nop;
        end else begin
            // one cycle per accepted strobe
            dec_valid <= accept;
            if (accept) begin
                dec_op <= field_op;
            end
        end
    end

    // immediate only changes with an accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_imm <= field_imm;
        end
    end

endmodule

/* verilog/result_writeback.sv */
// Result stage. Owns the accumulator, zero flag and output byte.
// ALU results and load data are written here, and ld / st turn into
// a one-cycle request toward the Wishbone manager.

module result_writeback #(
    parameter acc_cpu_pkg::word_t wb_base = 32'h3000_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dec_valid,
    input  acc_cpu_pkg::opcode_t dec_op,
    input  acc_cpu_pkg::imm_t    dec_imm,
    input  acc_cpu_pkg::acc_t    alu_result,
    input  logic                 rd_valid,
    input  acc_cpu_pkg::acc_t    rd_data,
    output acc_cpu_pkg::acc_t    acc,
    output acc_cpu_pkg::acc_t    out_byte,
    output logic                 zero_flag,
    output logic                 mem_read,
    output logic                 mem_write,
    output acc_cpu_pkg::word_t   mem_adr
);
    import acc_cpu_pkg::*;

    logic alu_write;

    // opcodes that take the ALU result
    assign alu_write = dec_valid &&
                       (dec_op == op_ldi || dec_op == op_addi ||
                        dec_op == op_subi || dec_op == op_xori);

    // request goes out in the same cycle as dec_valid
    // so busy is already up one edge later
    assign mem_read  = dec_valid && (dec_op == op_ld);
    assign mem_write = dec_valid && (dec_op == op_st);

    // word index times four on top of the base
    assign mem_adr = wb_base + {25'd0, dec_imm, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            out_byte  <= '0;
            zero_flag <= 1'b1;
        end else begin
            // load data first; decode is blocked while it is pending
            if (rd_valid) begin
                acc       <= rd_data;
                zero_flag <= (rd_data == '0);
            end else if (alu_write) begin
                acc       <= alu_result;
                zero_flag <= (alu_result == '0);
            end

            // out copies the current accumulator
            if (dec_valid && dec_op == op_out) begin
                out_byte <= acc;
            end
        end
    end

    // one request type at a time
    a_one_request: assert property (
        @(posedge clk) disable iff (reset)
        !(mem_read && mem_write)
    );

    // load data never collides with a fresh instruction
    a_rd_alone: assert property (
        @(posedge clk) disable iff (reset)
        rd_valid |-> !dec_valid
    );

endmodule

/* verilog/team_top.sv */
// Chip top level under the management core. Maps the breakout pins onto
// the decode, execute and result stages, and gates all pin outputs with
// en. The Wishbone master ports go straight to the bus interconnect.

module team_top #(
    parameter acc_cpu_pkg::word_t wb_base = 32'h3000_0000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               en,
    input  logic [33:0]        gpio_in,
    output logic [33:0]        gpio_out,
    output logic [33:0]        gpio_oeb,
    output acc_cpu_pkg::word_t wb_adr,
    output acc_cpu_pkg::word_t wb_dat_w,
    output logic [3:0]         wb_sel,
    output logic               wb_we,
    output logic               wb_stb,
    output logic               wb_cyc,
    input  acc_cpu_pkg::word_t wb_dat_r,
    input  logic               wb_ack
);
    import acc_cpu_pkg::*;

    logic    dec_valid;
    opcode_t dec_op;
    imm_t    dec_imm;
    acc_t    acc;
    acc_t    alu_result;
    acc_t    out_byte;
    logic    zero_flag;
    logic    mem_read;
    logic    mem_write;
    word_t   mem_adr;
    logic    busy;
    logic    rd_valid;
    acc_t    rd_data;

    instr_decode decode_inst (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .instr_byte (gpio_in[instr_lsb +: 8]),
        .strobe     (gpio_in[strobe_bit]),
        .busy       (busy),
        .dec_valid  (dec_valid),
        .dec_op     (dec_op),
        .dec_imm    (dec_imm)
    );

    alu_execute execute_inst (
        .acc        (acc),
        .dec_op     (dec_op),
        .dec_imm    (dec_imm),
        .alu_result (alu_result)
    );

    result_writeback #(
        .wb_base (wb_base)
    ) writeback_inst (
        .clk        (clk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .dec_op     (dec_op),
        .dec_imm    (dec_imm),
        .alu_result (alu_result),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .acc        (acc),
        .out_byte   (out_byte),
        .zero_flag  (zero_flag),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_adr    (mem_adr)
    );

    wishbone_manager wb_manager_inst (
        .clk       (clk),
        .reset     (reset),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_adr   (mem_adr),
        .acc       (acc),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_we     (wb_we),
        .wb_stb    (wb_stb),
        .wb_cyc    (wb_cyc),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    // pins idle as inputs driven low until enabled
    always_comb begin
        gpio_out = '0;
        gpio_oeb = '1;
        if (en) begin
            gpio_oeb[out_lsb +: status_pins] = '0;
            gpio_out[out_lsb +: 8]           = out_byte;
            gpio_out[busy_bit]               = busy;
            gpio_out[zero_bit]               = zero_flag;
        end
    end

endmodule

/* verilog/wishbone_manager.sv */
// Wishbone classic master. Takes one request strobe, runs a single
// bus cycle until ack, then hands back read data as a one-cycle pulse.
// Busy covers the whole cycle including the ack cycle.

module wishbone_manager (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_read,
    input  logic               mem_write,
    input  acc_cpu_pkg::word_t mem_adr,
    input  acc_cpu_pkg::acc_t  acc,
    output logic               busy,
    output logic               rd_valid,
    output acc_cpu_pkg::acc_t  rd_data,
    output acc_cpu_pkg::word_t wb_adr,
    output acc_cpu_pkg::word_t wb_dat_w,
    output logic [3:0]         wb_sel,
    output logic               wb_we,
    output logic               wb_stb,
    output logic               wb_cyc,
    input  acc_cpu_pkg::word_t wb_dat_r,
    input  logic               wb_ack
);
    import acc_cpu_pkg::*;

    typedef enum logic {
        idle,
        bus
    } state_t;

    state_t state;
    logic   request;

    assign request = mem_read || mem_write;

    // whole word lanes
    assign wb_sel = 4'hf;

    // busy straight from the state
    assign busy = (state == bus);

    // control flops
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            case (state)
                idle: begin
                    if (request) begin
                        // cyc and stb go up together
                        state  <= bus;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= mem_write;
                    end
                end
                bus: begin
                    // slave may stall for any number of cycles
                    if (wb_ack) begin
                        state    <= idle;
                        wb_cyc   <= 1'b0;
                        wb_stb   <= 1'b0;
                        wb_we    <= 1'b0;
                        rd_valid <= !wb_we;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // request payload held for the duration of the cycle
    always_ff @(posedge clk) begin
        if (state == idle && request) begin
            wb_adr   <= mem_adr;
            wb_dat_w <= {24'd0, acc};
        end
        // low byte is all the accumulator needs
        if (state == bus && wb_ack) begin
            rd_data <= wb_dat_r[7:0];
        end
    end

    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (reset)
        wb_stb |-> wb_cyc
    );

    // decode must hold off while a bus cycle runs
    a_no_req_busy: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !(mem_read || mem_write)
    );

endmodule
